// File: bht_stim.txt
# U pc target taken jump
# P pc exp_hit_pc exp_hit_pcp4 exp_target exp_taken exp_jump
P 00000100 0 0 00000000 0 0
U 00001000 00002000 1 0
P 00001000 1 0 00002000 1 0
U 00001000 00002000 0 0
U 00001000 00002000 0 0
P 00001000 1 0 00002000 0 0
U 00001000 00002000 1 0
U 00001000 00002000 1 0
P 00001000 1 0 00002000 1 0
U 00001000 00002000 0 0
U 00001000 00002000 0 0
P 00001000 1 0 00002000 1 0
U 00003004 00004000 1 1
P 00003000 0 1 00004000 1 1
U 00003000 00005000 0 0
P 00003000 1 1 00005000 1 0
U 00010008 0000a000 1 0
U 00020008 0000b000 1 1
U 00030008 0000c000 0 0
U 00040008 0000d000 1 0
P 00010008 1 0 0000a000 1 0
U 00050008 0000e000 1 1
P 00010008 0 0 00000000 0 0
P 00050008 1 0 0000e000 1 1
P 00020008 1 0 0000b000 1 1
P 00040008 1 0 0000d000 1 0

// File: flist.f
+incdir+.
bht_pkg.sv
lutram_3r1w.sv
plru_tracker.sv
bht_update_ctrl.sv
bht_way.sv
bht_hit_select.sv
bht_top.sv
bht_checker.sv
tb_bht.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f flist.f --top-module tb_bht -o sim_tb_bht
out=$(./obj_dir/sim_tb_bht)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// File: tb_bht.sv
`timescale 1ns/1ps

module tb_bht import bht_pkg::*; ();

    logic        clk;
    logic        rst;
    addr_t       pred_pc;
    logic        pred_hit_pc;
    logic        pred_hit_pcp4;
    addr_t       pred_target;
    logic        pred_taken;
    logic        pred_is_jump;
    logic        upd_req;
    addr_t       upd_pc;
    addr_t       upd_target;
    logic        upd_taken;
    logic        upd_is_jump;
    logic        upd_ack;
    logic        chk_valid;
    logic [35:0] exp_vec;  // hit_pc, hit_pcp4, target, taken, jump
    logic        report;
    int          run_errors;
    int          num_fails;

    bht_top u_bht_top (
        .clk(clk), .rst(rst), .pred_pc(pred_pc), .pred_hit_pc(pred_hit_pc),
        .pred_hit_pcp4(pred_hit_pcp4), .pred_target(pred_target), .pred_taken(pred_taken),
        .pred_is_jump(pred_is_jump), .upd_req(upd_req), .upd_pc(upd_pc),
        .upd_target(upd_target), .upd_taken(upd_taken), .upd_is_jump(upd_is_jump),
        .upd_ack(upd_ack)
    );

    bht_checker u_checker (
        .clk(clk), .chk_valid(chk_valid), .exp_vec(exp_vec), .pred_hit_pc(pred_hit_pc),
        .pred_hit_pcp4(pred_hit_pcp4), .pred_target(pred_target), .pred_taken(pred_taken),
        .pred_is_jump(pred_is_jump), .report(report), .run_errors(run_errors),
        .num_fails(num_fails)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic wait_ack(input logic level, input addr_t pc);
        int cycles;
        cycles = 0;
        while (upd_ack !== level && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (upd_ack !== level) begin
            $display("handshake timeout: ack did not go to %0b for pc %h", level, pc);
            run_errors++;
        end
    endtask

    // one four-phase training transfer
    task automatic train(input addr_t pc, input addr_t target, input logic taken,
                         input logic jump);
        @(posedge clk);
        upd_pc      <= pc;
        upd_target  <= target;
        upd_taken   <= taken;
        upd_is_jump <= jump;
        upd_req     <= 1'b1;
        wait_ack(1'b1, pc);
        upd_req <= 1'b0;
        wait_ack(1'b0, pc);
    endtask

    task automatic predict(input addr_t pc, input logic [35:0] expected);
        @(posedge clk);
        pred_pc   <= pc;
        exp_vec   <= expected;
        chk_valid <= 1'b1;  // checker samples on the next edge
        @(posedge clk);
        chk_valid <= 1'b0;
    endtask

    initial begin
        int          fd;
        string       line;
        logic [7:0]  op;
        logic [31:0] f [6];
        rst         = 1'b1;
        pred_pc     = '0;
        upd_req     = 1'b0;
        upd_pc      = '0;
        upd_target  = '0;
        upd_taken   = 1'b0;
        upd_is_jump = 1'b0;
        chk_valid   = 1'b0;
        exp_vec     = '0;
        report      = 1'b0;
        run_errors  = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("bht_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open bht_stim.txt for reading");
            run_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line.substr(0, 0) != "#") begin
                    void'($sscanf(line, "%c %h %h %h %h %h %h",
                                  op, f[0], f[1], f[2], f[3], f[4], f[5]));
                    if (op == "U") begin
                        train(f[0], f[1], f[2][0], f[3][0]);
                    end else if (op == "P") begin
                        predict(f[0], {f[1][0], f[2][0], f[3], f[4][0], f[5][0]});
                    end
                end
            end
            $fclose(fd);
        end
        @(posedge clk);
        report <= 1'b1;
        @(posedge clk);
        if (num_fails == 0 && run_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: bht_checker.sv
`timescale 1ns/1ps

module bht_checker import bht_pkg::*; (
    input  logic        clk,
    input  logic        chk_valid,
    input  logic [35:0] exp_vec,
    input  logic        pred_hit_pc,
    input  logic        pred_hit_pcp4,
    input  addr_t       pred_target,
    input  logic        pred_taken,
    input  logic        pred_is_jump,
    input  logic        report,
    input  int          run_errors,
    output int          num_fails
);

    int tests = 0;
    int fails = 0;

    assign num_fails = fails;

    // 1 on mismatch
    function automatic int field_bad(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: time %0t, %s expected %h got %h", $time, name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge clk) begin
        int bad;
        if (chk_valid) begin
            bad = field_bad("pred_hit_pc", 32'(exp_vec[35]), 32'(pred_hit_pc));
            bad += field_bad("pred_hit_pcp4", 32'(exp_vec[34]), 32'(pred_hit_pcp4));
            bad += field_bad("pred_target", exp_vec[33:2], pred_target);
            bad += field_bad("pred_taken", 32'(exp_vec[1]), 32'(pred_taken));
            bad += field_bad("pred_is_jump", 32'(exp_vec[0]), 32'(pred_is_jump));
            tests++;
            if (bad == 0) begin
                $display("test %0d: prediction ok", tests);
            end else begin
                fails++;
                $display("test %0d: %0d field(s) wrong", tests, bad);
            end
        end
    end

    always @(posedge report) begin
        $display("totals: %0d tests, %0d passed, %0d failed, %0d other errors",
                 tests, tests - fails, fails, run_errors);
    end

endmodule

// File: bht_top.sv
`timescale 1ns/1ps

`include "bht_config.svh"

module bht_top import bht_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t pred_pc,
    output logic  pred_hit_pc,
    output logic  pred_hit_pcp4,
    output addr_t pred_target,
    output logic  pred_taken,
    output logic  pred_is_jump,
    input  logic  upd_req,
    input  addr_t upd_pc,
    input  addr_t upd_target,
    input  logic  upd_taken,
    input  logic  upd_is_jump,
    output logic  upd_ack
);

    addr_t                  pred_pcp4;
    logic   [`BHT_WAYS-1:0] train_en;
    logic   [`BHT_WAYS-1:0] alloc_en;
    logic   [`BHT_WAYS-1:0] upd_hit;
    logic   [`BHT_WAYS-1:0] hit_a;
    logic   [`BHT_WAYS-1:0] hit_b;
    logic   [`BHT_WAYS-1:0] jump_a;
    logic   [`BHT_WAYS-1:0] jump_b;
    entry_t [`BHT_WAYS-1:0] entry_a;
    entry_t [`BHT_WAYS-1:0] entry_b;
    way_t                   victim;
    logic                   touch_en;
    way_t                   touch_way;

    assign pred_pcp4 = pred_pc + 32'd4;  // next fetch word

    bht_update_ctrl u_ctrl (
        .clk(clk), .rst(rst), .upd_req(upd_req), .upd_hit(upd_hit), .victim(victim),
        .upd_ack(upd_ack), .train_en(train_en), .alloc_en(alloc_en),
        .touch_en(touch_en), .touch_way(touch_way)
    );

    for (genvar g = 0; g < `BHT_WAYS; g++) begin : g_way
        bht_way u_way (
            .clk(clk), .rst(rst), .pc_a(pred_pc), .pc_b(pred_pcp4),
            .upd_pc(upd_pc), .upd_target(upd_target), .upd_taken(upd_taken),
            .upd_is_jump(upd_is_jump), .train_en(train_en[g]), .alloc_en(alloc_en[g]),
            .hit_a(hit_a[g]), .hit_b(hit_b[g]), .upd_hit(upd_hit[g]),
            .jump_a(jump_a[g]), .jump_b(jump_b[g]),
            .entry_a(entry_a[g]), .entry_b(entry_b[g])
        );
    end

    bht_hit_select u_sel (
        .hit_a(hit_a), .hit_b(hit_b), .jump_a(jump_a), .jump_b(jump_b),
        .entry_a(entry_a), .entry_b(entry_b),
        .pred_hit_pc(pred_hit_pc), .pred_hit_pcp4(pred_hit_pcp4),
        .pred_target(pred_target), .pred_taken(pred_taken), .pred_is_jump(pred_is_jump)
    );

    // replacement state follows the update set only
    plru_tracker u_plru (
        .clk(clk), .rst(rst), .set(pc_index(upd_pc)),
        .touch_en(touch_en), .touch_way(touch_way), .victim(victim)
    );

endmodule

// File: bht_hit_select.sv
`timescale 1ns/1ps

`include "bht_config.svh"

module bht_hit_select import bht_pkg::*; (
    input  logic   [`BHT_WAYS-1:0] hit_a,
    input  logic   [`BHT_WAYS-1:0] hit_b,
    input  logic   [`BHT_WAYS-1:0] jump_a,
    input  logic   [`BHT_WAYS-1:0] jump_b,
    input  entry_t [`BHT_WAYS-1:0] entry_a,
    input  entry_t [`BHT_WAYS-1:0] entry_b,
    output logic                   pred_hit_pc,
    output logic                   pred_hit_pcp4,
    output addr_t                  pred_target,
    output logic                   pred_taken,
    output logic                   pred_is_jump
);

    function automatic way_t first_way(logic [`BHT_WAYS-1:0] hits);
        way_t w;
        w = '0;
        for (int i = `BHT_WAYS-1; i >= 0; i--) begin
            if (hits[i]) begin
                w = way_t'(i);
            end
        end
        return w;
    endfunction

    way_t   way_a;
    way_t   way_b;
    entry_t sel_entry;
    logic   sel_jump;

    assign way_a = first_way(hit_a);
    assign way_b = first_way(hit_b);

    assign pred_hit_pc   = |hit_a;
    assign pred_hit_pcp4 = |hit_b;

    // pc beats pc+4
    always_comb begin
        sel_entry = '0;
        sel_jump  = 1'b0;
        if (pred_hit_pc) begin
            sel_entry = entry_a[way_a];
            sel_jump  = jump_a[way_a];
        end else if (pred_hit_pcp4) begin
            sel_entry = entry_b[way_b];
            sel_jump  = jump_b[way_b];
        end
    end

    assign pred_target  = sel_entry.target;
    assign pred_taken   = sel_entry.cnt[sel_entry.hist][`BHT_CNT_BITS-1];  // zero on miss
    assign pred_is_jump = sel_jump;

endmodule

// File: bht_way.sv
`timescale 1ns/1ps

`include "bht_config.svh"

module bht_way import bht_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  addr_t  pc_a,
    input  addr_t  pc_b,
    input  addr_t  upd_pc,
    input  addr_t  upd_target,
    input  logic   upd_taken,
    input  logic   upd_is_jump,
    input  logic   train_en,
    input  logic   alloc_en,
    output logic   hit_a,
    output logic   hit_b,
    output logic   upd_hit,
    output logic   jump_a,
    output logic   jump_b,
    output entry_t entry_a,
    output entry_t entry_b
);

    logic [`BHT_SETS-1:0] valid;
    meta_t    meta_a;
    meta_t    meta_b;
    meta_t    meta_c;
    meta_t    meta_wdata;
    entry_t   entry_c;
    entry_t   entry_wdata;
    counter_t cnt_old;
    counter_t cnt_new;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (alloc_en) begin
            valid[pc_index(upd_pc)] <= 1'b1;
        end
    end

    assign meta_wdata = '{tag: pc_tag(upd_pc), is_jump: upd_is_jump};

    lutram_3r1w #(.data_t(meta_t), .DEPTH(`BHT_SETS)) u_meta_ram (
        .clk(clk), .we(alloc_en), .waddr(pc_index(upd_pc)), .wdata(meta_wdata),
        .raddr_a(pc_index(pc_a)), .raddr_b(pc_index(pc_b)), .raddr_c(pc_index(upd_pc)),
        .rdata_a(meta_a), .rdata_b(meta_b), .rdata_c(meta_c)
    );

    lutram_3r1w #(.data_t(entry_t), .DEPTH(`BHT_SETS)) u_entry_ram (
        .clk(clk), .we(alloc_en | train_en), .waddr(pc_index(upd_pc)), .wdata(entry_wdata),
        .raddr_a(pc_index(pc_a)), .raddr_b(pc_index(pc_b)), .raddr_c(pc_index(upd_pc)),
        .rdata_a(entry_a), .rdata_b(entry_b), .rdata_c(entry_c)
    );

    assign hit_a   = valid[pc_index(pc_a)] && (meta_a.tag == pc_tag(pc_a));
    assign hit_b   = valid[pc_index(pc_b)] && (meta_b.tag == pc_tag(pc_b));
    assign upd_hit = valid[pc_index(upd_pc)] && (meta_c.tag == pc_tag(upd_pc));
    assign jump_a  = meta_a.is_jump;
    assign jump_b  = meta_b.is_jump;

    // saturating step of the history-selected counter
    always_comb begin
        cnt_old = entry_c.cnt[entry_c.hist];
        if (upd_taken) begin
            cnt_new = (cnt_old == '1) ? cnt_old : counter_t'(cnt_old + 1'b1);
        end else begin
            cnt_new = (cnt_old == '0) ? cnt_old : counter_t'(cnt_old - 1'b1);
        end
    end

    always_comb begin
        entry_wdata = entry_c;
        if (alloc_en) begin
            entry_wdata.target = upd_target;
            entry_wdata.hist   = '0;
            entry_wdata.cnt    = '1;  // start strongly taken
        end else begin
            entry_wdata.cnt[entry_c.hist] = cnt_new;
            entry_wdata.hist = {entry_c.hist[`BHT_HIST_BITS-2:0], upd_taken};
        end
    end

endmodule

// File: bht_update_ctrl.sv
`timescale 1ns/1ps

`include "bht_config.svh"

module bht_update_ctrl import bht_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 upd_req,
    input  logic [`BHT_WAYS-1:0] upd_hit,
    input  way_t                 victim,
    output logic                 upd_ack,
    output logic [`BHT_WAYS-1:0] train_en,
    output logic [`BHT_WAYS-1:0] alloc_en,
    output logic                 touch_en,
    output way_t                 touch_way
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        ACK
    } state_t;

    state_t state;
    state_t state_next;
    logic   any_hit;
    way_t   hit_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (upd_req) begin
                    state_next = WRITE;
                end
            end
            WRITE: begin
                state_next = ACK;  // single write cycle
            end
            ACK: begin
                if (!upd_req) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign upd_ack = (state == ACK);

    // lowest hitting way
    always_comb begin
        any_hit = 1'b0;
        hit_way = '0;
        for (int i = `BHT_WAYS-1; i >= 0; i--) begin
            if (upd_hit[i]) begin
                any_hit = 1'b1;
                hit_way = way_t'(i);
            end
        end
    end

    always_comb begin
        train_en = '0;
        alloc_en = '0;
        if (state == WRITE) begin
            if (any_hit) begin
                train_en[hit_way] = 1'b1;
            end else begin
                alloc_en[victim] = 1'b1;  // replace the victim on a miss
            end
        end
    end

    assign touch_en  = (state == WRITE);
    assign touch_way = any_hit ? hit_way : victim;

endmodule

// File: plru_tracker.sv
`timescale 1ns/1ps

`include "bht_config.svh"

module plru_tracker import bht_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  index_t set,
    input  logic   touch_en,
    input  way_t   touch_way,
    output way_t   victim
);

    plru_t tree [`BHT_SETS];
    plru_t cur;
    plru_t nxt;

    assign cur = tree[set];

    // bit 0 picks the half and bits 1/2 the way within it
    always_comb begin
        if (!cur[0]) begin
            victim = {1'b0, cur[1]};
        end else begin
            victim = {1'b1, cur[2]};
        end
    end

    // point the touched path away from the way
    always_comb begin
        nxt = cur;
        nxt[0] = ~touch_way[1];
        if (!touch_way[1]) begin
            nxt[1] = ~touch_way[0];
        end else begin
            nxt[2] = ~touch_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BHT_SETS; i++) begin
                tree[i] <= '0;  // first victim is way 0
            end
        end else if (touch_en) begin
            tree[set] <= nxt;
        end
    end

endmodule

// File: lutram_3r1w.sv
`timescale 1ns/1ps

module lutram_3r1w #(
    parameter type data_t = logic [7:0],
    parameter int  DEPTH  = 8,
    localparam int AW     = $clog2(DEPTH)
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  data_t         wdata,
    input  logic [AW-1:0] raddr_a,
    input  logic [AW-1:0] raddr_b,
    input  logic [AW-1:0] raddr_c,
    output data_t         rdata_a,
    output data_t         rdata_b,
    output data_t         rdata_c
);

    data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // one async read per lookup
    assign rdata_a = mem[raddr_a];
    assign rdata_b = mem[raddr_b];
    assign rdata_c = mem[raddr_c];

endmodule

// File: bht_pkg.sv
`include "bht_config.svh"

package bht_pkg;

    localparam int INDEX_BITS = $clog2(`BHT_SETS);
    localparam int WAY_BITS   = $clog2(`BHT_WAYS);
    localparam int TAG_BITS   = `BHT_PC_BITS - INDEX_BITS - 2;
    localparam int NUM_CNT    = 2 ** `BHT_HIST_BITS;  // one counter per history pattern

    typedef logic [`BHT_PC_BITS-1:0]   addr_t;
    typedef logic [INDEX_BITS-1:0]     index_t;
    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [WAY_BITS-1:0]       way_t;
    typedef logic [`BHT_WAYS-2:0]      plru_t;
    typedef logic [`BHT_HIST_BITS-1:0] hist_t;
    typedef logic [`BHT_CNT_BITS-1:0]  counter_t;

    typedef struct packed {
        tag_t tag;
        logic is_jump;
    } meta_t;

    typedef struct packed {
        addr_t                  target;
        hist_t                  hist;
        counter_t [NUM_CNT-1:0] cnt;
    } entry_t;

    function automatic index_t pc_index(addr_t pc);
        return pc[INDEX_BITS+1:2];  // word aligned
    endfunction

    function automatic tag_t pc_tag(addr_t pc);
        return pc[`BHT_PC_BITS-1:INDEX_BITS+2];
    endfunction

endpackage

// File: bht_config.svh
`ifndef BHT_CONFIG_SVH
`define BHT_CONFIG_SVH

// table geometry
`define BHT_WAYS      4
`define BHT_SETS      8

// per-entry predictor state
`define BHT_HIST_BITS 2
`define BHT_CNT_BITS  2

`define BHT_PC_BITS   32

`endif
